// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  - files:
      - source/decode_issue_pkg.sv
      - source/unit_classifier.sv
      - source/operand_decoder.sv
      - source/issue_control.sv
      - source/decode_issue.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/decode_issue_chk.sv
      - verif/decode_issue_tb.sv

// ==== decode_issue.f ====
source/decode_issue_pkg.sv
source/unit_classifier.sv
source/operand_decoder.sv
source/issue_control.sv
source/decode_issue.sv
verif/tb_clock_gen.sv
verif/decode_issue_chk.sv
verif/decode_issue_tb.sv

// ==== source/decode_issue.sv ====
// RV32I decode and issue with four units; no register data, renaming or M/A support
module decode_issue (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              decode_valid_i,
    input  decode_issue_pkg::xlen_t           decode_pc_i,
    input  decode_issue_pkg::instr_t          decode_instr_i,
    output logic                              decode_advance_o,

    output decode_issue_pkg::reg_addr_t [1:0] rs_addr_o,
    input  logic [1:0]                        rs_inuse_i,

    input  decode_issue_pkg::unit_vec_t       unit_ready_i,
    input  logic                              hold_i,
    input  logic                              flush_i,

    output decode_issue_pkg::issue_pkt_t      issue_pkt_o,
    output decode_issue_pkg::unit_vec_t       issue_to_o,
    output logic                              issued_o,
    output logic                              illegal_o
);
    import decode_issue_pkg::*;

    unit_info_t    info;
    operand_ctrl_t ctrl;

    // Both decoders look at the fetch word in parallel
    unit_classifier i_unit_classifier (
        .instr_i (decode_instr_i),
        .info_o  (info)
    );

    operand_decoder i_operand_decoder (
        .instr_i (decode_instr_i),
        .ctrl_o  (ctrl)
    );

    issue_control i_issue_control (
        .clk              (clk),
        .rst              (rst),
        .decode_valid_i   (decode_valid_i),
        .decode_pc_i      (decode_pc_i),
        .decode_instr_i   (decode_instr_i),
        .info_i           (info),
        .ctrl_i           (ctrl),
        .decode_advance_o (decode_advance_o),
        .rs_addr_o        (rs_addr_o),
        .rs_inuse_i       (rs_inuse_i),
        .unit_ready_i     (unit_ready_i),
        .hold_i           (hold_i),
        .flush_i          (flush_i),
        .issue_pkt_o      (issue_pkt_o),
        .issue_to_o       (issue_to_o),
        .issued_o         (issued_o),
        .illegal_o        (illegal_o)
    );

endmodule

// ==== source/decode_issue_pkg.sv ====
// RV32I base set only; M, A and compressed encodings are not decoded and opcode bits 1:0 are unchecked
package decode_issue_pkg;

    //////////////////////////////
    // Basic widths

    typedef logic [31:0] instr_t;
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    // Offsets are kept as plain vectors, already sign extended to their width
    typedef logic [20:0] pc_offset_t;
    typedef logic [11:0] ls_offset_t;

    //////////////////////////////
    // Encodings

    // Opcode bits 6:2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    localparam int NUM_UNITS = 4;

    // Bit positions in a unit vector
    typedef enum logic [1:0] {
        ALU = 2'd0,
        BR  = 2'd1,
        LS  = 2'd2,
        SYS = 2'd3
    } unit_id_t;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

    typedef enum logic [1:0] {
        CONSTANT = 2'd0,
        ADD_SUB  = 2'd1,
        SLT      = 2'd2,
        SHIFT    = 2'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        XOR = 2'd1,
        OR  = 2'd2,
        AND = 2'd3
    } alu_logic_op_t;

    //////////////////////////////
    // Decoder results and issue packet

    typedef struct packed {
        unit_vec_t unit_needed;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      uses_rd;
    } unit_info_t;

    typedef struct packed {
        alu_op_t       alu_op;
        alu_logic_op_t logic_op;
        logic          subtract;
        logic          sel_pc;
        xlen_t         imm;
        pc_offset_t    pc_offset;
        ls_offset_t    ls_offset;
        logic          is_load;
        logic          is_store;
    } operand_ctrl_t;

    typedef struct packed {
        xlen_t         pc;
        reg_addr_t     rs1_addr;
        reg_addr_t     rs2_addr;
        reg_addr_t     rd_addr;
        logic [2:0]    fn3;
        unit_info_t    info;
        operand_ctrl_t ctrl;
    } issue_pkt_t;

endpackage

// ==== source/issue_control.sv ====
// One-entry issue stage; a jump strobes BR and ALU together and waits until both are ready
module issue_control (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            decode_valid_i,
    input  decode_issue_pkg::xlen_t         decode_pc_i,
    input  decode_issue_pkg::instr_t        decode_instr_i,
    input  decode_issue_pkg::unit_info_t    info_i,
    input  decode_issue_pkg::operand_ctrl_t ctrl_i,
    output logic                            decode_advance_o,

    output decode_issue_pkg::reg_addr_t [1:0] rs_addr_o,
    input  logic [1:0]                      rs_inuse_i,

    input  decode_issue_pkg::unit_vec_t     unit_ready_i,
    input  logic                            hold_i,
    input  logic                            flush_i,

    output decode_issue_pkg::issue_pkt_t    issue_pkt_o,
    output decode_issue_pkg::unit_vec_t     issue_to_o,
    output logic                            issued_o,
    output logic                            illegal_o
);
    import decode_issue_pkg::*;

    issue_pkt_t next_pkt;
    issue_pkt_t stage_pkt;
    logic       stage_valid;

    logic       rs1_conflict;
    logic       rs2_conflict;
    logic       operands_ready;
    logic       no_unit;
    logic       units_ready;
    logic       can_act;
    logic       issue_fire;
    logic       illegal_fire;
    logic       stage_ready;

    //////////////////////////////
    // Packet entering the stage

    assign next_pkt.pc       = decode_pc_i;
    assign next_pkt.rs1_addr = decode_instr_i[19:15];
    assign next_pkt.rs2_addr = decode_instr_i[24:20];
    assign next_pkt.rd_addr  = decode_instr_i[11:7];
    assign next_pkt.fn3      = decode_instr_i[14:12];
    assign next_pkt.info     = info_i;
    assign next_pkt.ctrl     = ctrl_i;

    // Stage frees up in the same cycle its instruction leaves
    assign stage_ready      = !stage_valid || issue_fire || illegal_fire;
    assign decode_advance_o = decode_valid_i && stage_ready;

    // A flush wins over any transfer in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= decode_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance_o) begin
            stage_pkt <= next_pkt;
        end
    end

    //////////////////////////////
    // Issue decision

    // Scoreboard lookup for the instruction held in the stage
    assign rs_addr_o[0] = stage_pkt.rs1_addr;
    assign rs_addr_o[1] = stage_pkt.rs2_addr;

    assign rs1_conflict   = rs_inuse_i[0] && stage_pkt.info.uses_rs1;
    assign rs2_conflict   = rs_inuse_i[1] && stage_pkt.info.uses_rs2;
    assign operands_ready = !rs1_conflict && !rs2_conflict;

    assign no_unit     = (stage_pkt.info.unit_needed == '0);
    assign units_ready = !no_unit
                         && ((stage_pkt.info.unit_needed & ~unit_ready_i) == '0);

    assign can_act = stage_valid && !hold_i && !flush_i;

    assign issue_fire = can_act && operands_ready && units_ready;

    // Illegal drop does not wait for operands
    assign illegal_fire = can_act && no_unit;

    assign issue_to_o  = {NUM_UNITS{issue_fire}} & stage_pkt.info.unit_needed;
    assign issued_o    = |issue_to_o;
    assign illegal_o   = illegal_fire;
    assign issue_pkt_o = stage_pkt;

endmodule

// ==== source/operand_decoder.sv ====
// Purely combinational; fields are decoded for every opcode and are only meaningful to the unit used
module operand_decoder (
    input  decode_issue_pkg::instr_t        instr_i,
    output decode_issue_pkg::operand_ctrl_t ctrl_o
);
    import decode_issue_pkg::*;

    // fn3 values of the integer operations
    localparam logic [2:0] FN3_ADD_SUB = 3'b000;
    localparam logic [2:0] FN3_SLL     = 3'b001;
    localparam logic [2:0] FN3_SLT     = 3'b010;
    localparam logic [2:0] FN3_SLTU    = 3'b011;
    localparam logic [2:0] FN3_XOR     = 3'b100;
    localparam logic [2:0] FN3_SRX     = 3'b101;
    localparam logic [2:0] FN3_OR      = 3'b110;
    localparam logic [2:0] FN3_AND     = 3'b111;

    opcode_t       opcode;
    logic [2:0]    fn3;

    alu_op_t       alu_op;
    alu_logic_op_t logic_op;
    logic          sub_op;

    logic [19:0]   jal_imm;
    logic [11:0]   i_imm;
    logic [11:0]   br_imm;
    logic [11:0]   st_imm;
    pc_offset_t    pc_offset;

    assign opcode = opcode_t'(instr_i[6:2]);
    assign fn3    = instr_i[14:12];

    //////////////////////////////
    // ALU control

    always_comb begin
        case (opcode)
            LUI, AUIPC, JAL, JALR: begin
                alu_op = CONSTANT;
            end
            default: begin
                case (fn3)
                    FN3_SLT, FN3_SLTU: alu_op = SLT;
                    FN3_SLL, FN3_SRX:  alu_op = SHIFT;
                    default:           alu_op = ADD_SUB;
                endcase
            end
        endcase
    end

    always_comb begin
        case (fn3)
            FN3_XOR: logic_op = XOR;
            FN3_OR:  logic_op = OR;
            FN3_AND: logic_op = AND;
            default: logic_op = ADD;
        endcase
    end

    // SLT compares through the subtractor
    assign sub_op = (fn3 inside {FN3_SLT, FN3_SLTU})
                    || ((opcode == ARITH) && (fn3 == FN3_ADD_SUB) && instr_i[30]);

    //////////////////////////////
    // Immediates and offsets

    assign i_imm   = instr_i[31:20];
    assign st_imm  = {instr_i[31:25], instr_i[11:7]};
    assign jal_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21]};
    assign br_imm  = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};

    // Opcode bits 3:2 tell JAL, JALR and BRANCH apart
    always_comb begin
        case (instr_i[3:2])
            2'b11:   pc_offset = {jal_imm, 1'b0};
            2'b01:   pc_offset = {{9{i_imm[11]}}, i_imm};
            default: pc_offset = {{8{br_imm[11]}}, br_imm, 1'b0};
        endcase
    end

    assign ctrl_o.alu_op   = alu_op;
    assign ctrl_o.logic_op = logic_op;
    assign ctrl_o.subtract = sub_op;
    assign ctrl_o.sel_pc   = opcode inside {AUIPC, JAL, JALR, BRANCH};

    // Upper immediate for LUI and AUIPC
    assign ctrl_o.imm = (opcode inside {LUI, AUIPC}) ? {instr_i[31:12], 12'b0}
                                                    : {{20{i_imm[11]}}, i_imm};

    assign ctrl_o.pc_offset = pc_offset;
    assign ctrl_o.ls_offset = (opcode == STORE) ? st_imm : i_imm;
    assign ctrl_o.is_load   = (opcode == LOAD);
    assign ctrl_o.is_store  = (opcode == STORE);

endmodule

// ==== source/unit_classifier.sv ====
// Purely combinational; multiply/divide and unknown opcodes give an empty unit vector
module unit_classifier (
    input  decode_issue_pkg::instr_t     instr_i,
    output decode_issue_pkg::unit_info_t info_o
);
    import decode_issue_pkg::*;

    opcode_t    opcode;
    logic [2:0] fn3;

    logic       mul_div_op;
    logic       csr_imm_op;
    logic       env_op;

    unit_vec_t  unit_needed;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       uses_rd;

    //////////////////////////////
    // Instruction fields

    assign opcode = opcode_t'(instr_i[6:2]);
    assign fn3    = instr_i[14:12];

    // M extension shares the ARITH opcode, marked by bit 25
    assign mul_div_op = (opcode == ARITH) && instr_i[25];

    // CSR forms taking a 5-bit immediate in the rs1 field
    assign csr_imm_op = (opcode == SYSTEM) && fn3[2];

    // ecall, ebreak and the returns
    assign env_op = (opcode == SYSTEM) && (fn3 == 3'b000);

    //////////////////////////////
    // Unit selection

    // Jumps need both BR and ALU, the ALU writes the link address
    always_comb begin
        unit_needed = '0;

        unit_needed[BR] = opcode inside {BRANCH, JAL, JALR};

        unit_needed[ALU] = (opcode inside {ARITH, ARITH_IMM, LUI, AUIPC, JAL, JALR})
                           && !mul_div_op;

        unit_needed[LS] = opcode inside {LOAD, STORE};

        unit_needed[SYS] = opcode inside {SYSTEM, FENCE};
    end

    //////////////////////////////
    // Register usage

    assign uses_rs1 = !((opcode inside {LUI, AUIPC, JAL, FENCE}) || csr_imm_op || env_op);

    assign uses_rs2 = opcode inside {BRANCH, STORE, ARITH};

    // Writes to x0 still count as using rd
    assign uses_rd = !((opcode inside {BRANCH, STORE, FENCE}) || env_op);

    assign info_o.unit_needed = unit_needed;
    assign info_o.uses_rs1    = uses_rs1;
    assign info_o.uses_rs2    = uses_rs2;
    assign info_o.uses_rd     = uses_rd;

endmodule

// ==== verif/decode_issue_chk.sv ====
// Checks only the issue handshake of issue_control; all properties are off during reset
module decode_issue_chk (
    input logic                        clk,
    input logic                        rst,
    input logic                        decode_valid_i,
    input logic                        decode_advance_o,
    input logic                        hold_i,
    input logic                        flush_i,
    input decode_issue_pkg::unit_vec_t issue_to_o,
    input logic                        illegal_o
);
    import decode_issue_pkg::*;

    // One unit per issue, except a jump which strobes BR and ALU together
    a_issue_shape: assert property (@(posedge clk) disable iff (rst)
        $onehot0(issue_to_o) || (issue_to_o == 4'b0011))
        else $error("issue_to_o has an illegal unit pattern %b", issue_to_o);

    a_issue_or_illegal: assert property (@(posedge clk) disable iff (rst)
        !((|issue_to_o) && illegal_o))
        else $error("issue and illegal strobes high together");

    a_blocked: assert property (@(posedge clk) disable iff (rst)
        (hold_i || flush_i) |-> (issue_to_o == '0))
        else $error("issue while hold or flush is high");

    a_advance: assert property (@(posedge clk) disable iff (rst)
        decode_advance_o |-> decode_valid_i)
        else $error("advance without a valid instruction");

endmodule

bind issue_control decode_issue_chk i_chk (
    .clk              (clk),
    .rst              (rst),
    .decode_valid_i   (decode_valid_i),
    .decode_advance_o (decode_advance_o),
    .hold_i           (hold_i),
    .flush_i          (flush_i),
    .issue_to_o       (issue_to_o),
    .illegal_o        (illegal_o)
);

// ==== verif/decode_issue_tb.sv ====
// Inputs change on falling edges and outputs are sampled 1 unit later; one instruction in flight
module decode_issue_tb;
    import decode_issue_pkg::*;

    localparam int NUM_VECS   = 17;
    localparam int NUM_RANDOM = 200;
    localparam int MAX_CYCLES = 40 * NUM_VECS + 8 * NUM_RANDOM;

    typedef struct packed {
        instr_t     instr;
        logic [1:0] inuse;
        unit_vec_t  ready;
        logic [3:0] hold;
        logic       flush;
        logic       stall;
        unit_vec_t  unit;
        reg_addr_t  rd;
        xlen_t      imm;
        pc_offset_t pcoff;
        alu_op_t    alu;
    } vec_t;

    logic clk;
    logic rst;
    logic decode_valid_i;
    xlen_t decode_pc_i;
    instr_t decode_instr_i;
    logic decode_advance_o;
    reg_addr_t [1:0] rs_addr_o;
    logic [1:0] rs_inuse_i;
    unit_vec_t unit_ready_i;
    logic hold_i;
    logic flush_i;
    issue_pkt_t issue_pkt_o;
    unit_vec_t issue_to_o;
    logic issued_o;
    logic illegal_o;

    vec_t vecs [NUM_VECS];
    string names [NUM_VECS];
    int num_added = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    logic [31:0] rand_state = 32'd71;

    tb_clock_gen i_clk_gen (.clk_o(clk), .rst_o(rst));

    decode_issue i_dut (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////
    // Reference decode from the rules

    function automatic logic [31:0] xorshift();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic unit_vec_t ref_unit(input instr_t w);
        logic [4:0] op;
        unit_vec_t u;
        op = w[6:2];
        u = '0;
        u[1] = op inside {BRANCH, JAL, JALR};
        u[0] = (op inside {ARITH, ARITH_IMM, LUI, AUIPC, JAL, JALR}) && !(op == ARITH && w[25]);
        u[2] = op inside {LOAD, STORE};
        u[3] = op inside {SYSTEM, FENCE};
        return u;
    endfunction

    function automatic xlen_t ref_imm(input instr_t w);
        if (w[6:2] inside {LUI, AUIPC})
            return {w[31:12], 12'b0};
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic pc_offset_t ref_pcoff(input instr_t w);
        if (w[3:2] == 2'b11)
            return {w[31], w[19:12], w[20], w[30:21], 1'b0};
        if (w[3:2] == 2'b01)
            return {{9{w[31]}}, w[31:20]};
        return {{8{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic alu_op_t ref_alu(input instr_t w);
        if (w[6:2] inside {LUI, AUIPC, JAL, JALR})
            return CONSTANT;
        if (w[14:12] inside {3'd2, 3'd3})
            return SLT;
        if (w[14:12] inside {3'd1, 3'd5})
            return SHIFT;
        return ADD_SUB;
    endfunction

    function automatic alu_logic_op_t ref_logic(input instr_t w);
        case (w[14:12])
            3'd4: return XOR;
            3'd6: return OR;
            3'd7: return AND;
            default: return ADD;
        endcase
    endfunction

    function automatic logic ref_sub(input instr_t w);
        return (w[14:12] inside {3'd2, 3'd3}) || (w[6:2] == ARITH && w[14:12] == 3'd0 && w[30]);
    endfunction

    function automatic ls_offset_t ref_ls(input instr_t w);
        return (w[6:2] == STORE) ? {w[31:25], w[11:7]} : w[31:20];
    endfunction

    ////////////////////////////////
    // Reporting

    task automatic check_field(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: %s expected %h actual %h", name, field, exp, act);
            err_count++;
        end
    endtask

    task automatic report_problem(input string name, input string msg);
        $display("%s: %s", name, msg);
        err_count++;
    endtask

    // Whole packet against the reference decode
    task automatic compare_pkt(input string name, input instr_t w, input xlen_t pc);
        check_field(name, "unit", ref_unit(w), issue_to_o);
        check_field(name, "pc", pc, issue_pkt_o.pc);
        check_field(name, "rs1_addr", w[19:15], rs_addr_o[0]);
        check_field(name, "rs2_addr", w[24:20], rs_addr_o[1]);
        check_field(name, "rd", w[11:7], issue_pkt_o.rd_addr);
        check_field(name, "imm", ref_imm(w), issue_pkt_o.ctrl.imm);
        check_field(name, "pc_offset", ref_pcoff(w), issue_pkt_o.ctrl.pc_offset);
        check_field(name, "ls_offset", ref_ls(w), issue_pkt_o.ctrl.ls_offset);
        check_field(name, "alu_op", ref_alu(w), issue_pkt_o.ctrl.alu_op);
        check_field(name, "logic_op", ref_logic(w), issue_pkt_o.ctrl.logic_op);
        check_field(name, "subtract", ref_sub(w), issue_pkt_o.ctrl.subtract);
    endtask

    task automatic add_vec(input string name, input instr_t instr, input logic [1:0] inuse,
                           input unit_vec_t ready, input int hold, input logic flush,
                           input logic stall, input unit_vec_t unit, input reg_addr_t rd,
                           input xlen_t imm, input pc_offset_t pcoff, input alu_op_t alu);
        names[num_added] = name;
        vecs[num_added] = '{instr, inuse, ready, hold[3:0], flush, stall, unit, rd, imm,
                            pcoff, alu};
        num_added++;
    endtask

    ////////////////////////////////
    // Table entry run

    task automatic run_entry(input int i);
        vec_t v;
        xlen_t pc;
        int start_err;
        int stall_len;
        int k;
        logic seen_issue;
        logic seen_illegal;
        v = vecs[i];
        pc = 32'h100 + 4 * i;
        start_err = err_count;
        seen_issue = 1'b0;
        seen_illegal = 1'b0;
        stall_len = (v.hold != 0) ? v.hold : 4;
        @(negedge clk);
        decode_valid_i = 1'b1;
        decode_instr_i = v.instr;
        decode_pc_i = pc;
        rs_inuse_i = v.inuse;
        unit_ready_i = v.ready;
        hold_i = (v.hold != 0);
        #1;
        while (!decode_advance_o) begin
            @(negedge clk);
            #1;
        end
        // A follower waits at the input while the stage is blocked
        if (v.stall || v.flush) begin
            for (k = 0; k < stall_len; k++) begin
                @(negedge clk);
                decode_instr_i = 32'h00000013;
                #1;
                if (issued_o || illegal_o)
                    report_problem(names[i], "instruction left the stage while blocked");
                if (decode_advance_o)
                    report_problem(names[i], "advance was high while the stage was blocked");
            end
        end
        if (v.flush) begin
            @(negedge clk);
            flush_i = 1'b1;
            #1;
        end
        @(negedge clk);
        decode_valid_i = 1'b0;
        flush_i = 1'b0;
        hold_i = 1'b0;
        if (v.stall || v.flush) begin
            rs_inuse_i = 2'b00;
            unit_ready_i = 4'hF;
        end
        #1;
        for (k = 0; k < 8; k++) begin
            if (issued_o && !seen_issue && !seen_illegal) begin
                seen_issue = 1'b1;
                check_field(names[i], "unit", v.unit, issue_to_o);
                check_field(names[i], "rd", v.rd, issue_pkt_o.rd_addr);
                check_field(names[i], "imm", v.imm, issue_pkt_o.ctrl.imm);
                check_field(names[i], "pc_offset", v.pcoff, issue_pkt_o.ctrl.pc_offset);
                check_field(names[i], "alu_op", v.alu, issue_pkt_o.ctrl.alu_op);
                compare_pkt(names[i], v.instr, pc);
            end else if (illegal_o && !seen_issue && !seen_illegal) begin
                seen_illegal = 1'b1;
            end else if (issued_o || illegal_o) begin
                report_problem(names[i], "a second issue or illegal pulse followed");
            end
            @(negedge clk);
            #1;
        end
        if (v.flush) begin
            if (seen_issue || seen_illegal)
                report_problem(names[i], "flushed instruction still left the stage");
        end else if (v.unit == '0) begin
            if (!seen_illegal)
                report_problem(names[i], "no illegal pulse for an instruction without a unit");
            if (seen_issue)
                report_problem(names[i], "illegal instruction was issued");
        end else if (!seen_issue) begin
            report_problem(names[i], "instruction was never issued");
        end
        tests_run++;
        if (err_count != start_err)
            tests_failed++;
        $display("Test %-12s %s", names[i], (err_count == start_err) ? "ok" : "failed");
    endtask

    ////////////////////////////////
    // Random run

    task automatic run_random();
        logic [4:0] ops [12];
        instr_t w;
        xlen_t pc;
        logic [31:0] r;
        string name;
        int start_err;
        int n;
        int k;
        logic done;
        ops = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH, FENCE, SYSTEM,
                5'b11111};
        start_err = err_count;
        for (n = 0; n < NUM_RANDOM; n++) begin
            name = $sformatf("random_%0d", n);
            w = xorshift();
            r = xorshift();
            w[6:0] = {ops[r % 12], 2'b11};
            pc = {r[31:2], 2'b00};
            @(negedge clk);
            decode_valid_i = 1'b1;
            decode_instr_i = w;
            decode_pc_i = pc;
            #1;
            while (!decode_advance_o) begin
                @(negedge clk);
                #1;
            end
            done = 1'b0;
            k = 0;
            while (!done) begin
                @(negedge clk);
                decode_valid_i = 1'b0;
                r = xorshift();
                // Readiness becomes certain after four cycles
                unit_ready_i = (k < 4) ? r[3:0] : 4'hF;
                rs_inuse_i = (k < 4) ? r[5:4] : 2'b00;
                hold_i = (k < 4) && (r[7:6] == 2'b00);
                #1;
                if (issued_o) begin
                    done = 1'b1;
                    compare_pkt(name, w, pc);
                end else if (illegal_o) begin
                    done = 1'b1;
                    if (ref_unit(w) != '0)
                        report_problem(name, "legal instruction reported as illegal");
                end
                k++;
            end
        end
        tests_run++;
        if (err_count != start_err)
            tests_failed++;
        $display("Test %-12s %s", "random", (err_count == start_err) ? "ok" : "failed");
    endtask

    initial begin
        decode_valid_i = 1'b0;
        decode_pc_i = '0;
        decode_instr_i = 32'h00000013;
        rs_inuse_i = 2'b00;
        unit_ready_i = 4'hF;
        hold_i = 1'b0;
        flush_i = 1'b0;

        // Unit selection and operand fields
        add_vec("lui", 32'h123452B7, 2'b00, 4'hF, 0, 0, 0, 4'b0001, 5'd5, 32'h12345000,
                21'h00123, CONSTANT);
        add_vec("auipc", 32'h00001097, 2'b00, 4'hF, 0, 0, 0, 4'b0001, 5'd1, 32'h00001000,
                21'h00000, CONSTANT);
        add_vec("jal", 32'h008000EF, 2'b00, 4'hF, 0, 0, 0, 4'b0011, 5'd1, 32'h00000008,
                21'h00008, CONSTANT);
        add_vec("jalr", 32'h010100E7, 2'b00, 4'hF, 0, 0, 0, 4'b0011, 5'd1, 32'h00000010,
                21'h00010, CONSTANT);
        add_vec("beq", 32'hFE208EE3, 2'b00, 4'hF, 0, 0, 0, 4'b0010, 5'd29, 32'hFFFFFFE2,
                21'h1FFFFC, ADD_SUB);
        add_vec("lw", 32'h00822183, 2'b00, 4'hF, 0, 0, 0, 4'b0100, 5'd3, 32'h00000008,
                21'h00802, SLT);
        add_vec("sw", 32'h00532623, 2'b00, 4'hF, 0, 0, 0, 4'b0100, 5'd12, 32'h00000005,
                21'h0000C, SLT);
        add_vec("slt", 32'h0020A3B3, 2'b00, 4'hF, 0, 0, 0, 4'b0001, 5'd7, 32'h00000002,
                21'h00806, SLT);
        add_vec("sub", 32'h40418433, 2'b00, 4'hF, 0, 0, 0, 4'b0001, 5'd8, 32'h00000404,
                21'h00408, ADD_SUB);
        add_vec("fence", 32'h0FF0000F, 2'b00, 4'hF, 0, 0, 0, 4'b1000, 5'd0, 32'h000000FF,
                21'h008FE, ADD_SUB);
        // Stalls and back-pressure
        add_vec("stall_rs1", 32'h00150493, 2'b01, 4'hF, 0, 0, 1, 4'b0001, 5'd9, 32'h00000001,
                21'h00808, ADD_SUB);
        add_vec("unused_rs2", 32'h00150493, 2'b10, 4'hF, 0, 0, 0, 4'b0001, 5'd9,
                32'h00000001, 21'h00808, ADD_SUB);
        add_vec("unit_busy", 32'h00822183, 2'b00, 4'b1011, 0, 0, 1, 4'b0100, 5'd3,
                32'h00000008, 21'h00802, SLT);
        add_vec("hold", 32'h0020A3B3, 2'b00, 4'hF, 3, 0, 1, 4'b0001, 5'd7, 32'h00000002,
                21'h00806, SLT);
        // Illegal and flush
        add_vec("mul", 32'h023100B3, 2'b00, 4'hF, 0, 0, 0, 4'b0000, 5'd0, '0, '0, CONSTANT);
        add_vec("unknown", 32'h0000007F, 2'b00, 4'hF, 0, 0, 0, 4'b0000, 5'd0, '0, '0,
                CONSTANT);
        add_vec("flush", 32'h00150493, 2'b01, 4'hF, 0, 1, 1, 4'b0001, 5'd9, 32'h00000001,
                21'h00808, ADD_SUB);

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (int i = 0; i < NUM_VECS; i++) begin
            run_entry(i);
        end
        run_random();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
// Fixed period of 40 time units; reset stays high for the first 16 rising edges
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #20 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule
